// File: filelist.f
spl_code_pkg.sv
spl_pkt_pkg.sv
spl_symbol_rx.sv
spl_pkt_assembler.sv
spl_pkt_out.sv
spl_receiver.sv
tb_clock_gen.sv
tb_spl_receiver.sv

// File: run.sh
#!/bin/sh
# builds the receiver testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_spl_receiver -f filelist.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

// File: tb_spl_receiver.sv
// receiver testbench driving random link packets and checking them against a queue model
`default_nettype none

module tb_spl_receiver;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS    = 100;
  localparam int N_PKTS    = 25;                         // packets over all six tests
  localparam int WD_NS     = N_PKTS * 30 * 20 * CLK_NS;  // 30 symbols of 20 cycles each
  localparam int STALL_CYC = 200;                        // ack silence that means stalled
  localparam spl_code_pkg::sym_t ERR_PAT = 7'b0010101;   // three wires, never a code

  logic                   clk;
  logic                   rst;
  spl_code_pkg::sym_t     sl_data = '0;
  logic                   sl_ack;
  spl_pkt_pkg::pkt_data_t pkt_data;
  logic                   pkt_vld;
  logic                   pkt_rdy = 1'b1;
  logic                   flt_err;
  logic                   frm_err;
  logic                   gch_err;

  spl_code_pkg::sym_t     wires = '0;      // sender copy of the wire levels
  logic                   ack_seen = 1'b0; // ack level the sender last saw
  logic [31:0]            lfsr_dat = 32'hfa9b;
  logic [31:0]            lfsr_rdy = 32'hfa9b;
  int                     rdy_mode = 1;    // 0 low, 1 high, 2 random
  spl_code_pkg::nibble_t  nibs [spl_pkt_pkg::LPKT_FLTS];
  int                     n_nibs;
  spl_pkt_pkg::pkt_data_t exp_q [$];       // expected packets, oldest first
  string                  test_name = "reset";
  int errs = 0;
  int err_at;                              // counter snapshots at test start
  int frm_at;
  int flt_at;
  int gch_at;
  int tests_ok = 0;
  int tests_bad = 0;

  // written by the output monitor only
  int rcv_idx = 0;
  int mon_errs = 0;
  int frm_hi = 0;
  int flt_hi = 0;
  int gch_hi = 0;
  logic last_vld = 1'b0;
  logic last_rdy = 1'b0;
  spl_pkt_pkg::pkt_data_t last_data;

  tb_clock_gen clk_i (.clk(clk), .rst(rst));

  spl_receiver dut_i (
    .CLK_IN   (clk),
    .RESET_IN (rst),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flt_err  (flt_err),
    .frm_err  (frm_err),
    .gch_err  (gch_err)
  );

  // ----------------------------------------------------------------------
  // random source and packet model

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois form
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_dat = lfsr_step(lfsr_dat);  // one step per bit taken
      v = {v[30:0], lfsr_dat[0]};
    end
    return v;
  endfunction

  task automatic make_pkt();
    nibs[0] = spl_code_pkg::nibble_t'(rand_bits(4));
    n_nibs  = nibs[0][1] ? spl_pkt_pkg::LPKT_FLTS : spl_pkt_pkg::SPKT_FLTS;  // header length bit
    for (int i = 1; i < n_nibs; i++)
      nibs[i] = spl_code_pkg::nibble_t'(rand_bits(4));
  endtask

  // nibble i lands at bits 4i+3..4i
  // short packets leave the top 32 bits zero
  function automatic spl_pkt_pkg::pkt_data_t expect_data();
    spl_pkt_pkg::pkt_data_t d;
    d = '0;
    for (int i = 0; i < n_nibs; i++)
      d[4*i +: 4] = nibs[i];
    return d;
  endfunction

  // ----------------------------------------------------------------------
  // link sender model that starts and ends on a falling edge

  task automatic wait_ack();
    @(negedge clk);
    while (sl_ack == ack_seen)
      @(negedge clk);
    ack_seen = sl_ack;
  endtask

  task automatic send_sym(input spl_code_pkg::sym_t code);
    wires   = wires ^ code;  // NRZ toggles the wires of the code
    sl_data = wires;
    wait_ack();
  endtask

  task automatic glitch_wires();
    sl_data = wires ^ ERR_PAT;     // one cycle only
    @(negedge clk);
    sl_data = wires;
    repeat (6) @(negedge clk);
  endtask

  task automatic send_nibs(input int n, input int bad_at, input int glitch_at);
    for (int i = 0; i < n; i++) begin
      if (i == glitch_at)
        glitch_wires();
      if (i == bad_at)
        send_sym(ERR_PAT);       // held until acked so it becomes a bad flit
      else
        send_sym(spl_code_pkg::NIB_CODE[nibs[i]]);
    end
    send_sym(spl_code_pkg::EOP_CODE);
  endtask

  task automatic send_good(input int glitch_at);
    make_pkt();
    exp_q.push_back(expect_data());
    send_nibs(n_nibs, -1, glitch_at);
  endtask

  // mode changes on a rising edge and the driver picks it up on the next fall
  task automatic set_rdy(input int mode);
    @(posedge clk);
    rdy_mode = mode;
    @(negedge clk);
  endtask

  always @(negedge clk) begin
    if (rdy_mode == 2) begin
      lfsr_rdy = lfsr_step(lfsr_rdy);
      pkt_rdy  = lfsr_rdy[0];
    end else begin
      pkt_rdy = (rdy_mode == 1);
    end
  end

  // ----------------------------------------------------------------------
  // output monitor that sees the values from before the edge

  always @(posedge clk) begin
    if (!rst) begin
      if (last_vld && !last_rdy) begin
        assert (pkt_vld && pkt_data == last_data) else begin
          $display("FAIL %s held packet expected %h actual %h", test_name, last_data, pkt_data);
          mon_errs++;
        end
      end
      if (pkt_vld && pkt_rdy) begin
        assert (rcv_idx < exp_q.size()) else begin
          $display("%s: a packet came out that was never sent", test_name);
          mon_errs++;
        end
        if (rcv_idx < exp_q.size()) begin
          assert (pkt_data == exp_q[rcv_idx]) else begin
            $display("FAIL %s expected %h actual %h", test_name, exp_q[rcv_idx], pkt_data);
            mon_errs++;
          end
          rcv_idx++;
        end
      end
      frm_hi = frm_hi + int'(frm_err);   // cycles high where one pulse counts two
      flt_hi = flt_hi + int'(flt_err);
      gch_hi = gch_hi + int'(gch_err);
      last_vld  = pkt_vld;
      last_rdy  = pkt_rdy;
      last_data = pkt_data;
    end
  end

  // ----------------------------------------------------------------------
  // test bookkeeping

  task automatic start_test(input string name);
    test_name = name;
    err_at = errs + mon_errs;
    frm_at = frm_hi;
    flt_at = flt_hi;
    gch_at = gch_hi;
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("FAIL %s %s expected %0d actual %0d", test_name, what, expected, actual);
      errs++;
    end
  endtask

  task automatic end_test(input int frm_exp, input int flt_exp, input int gch_exp);
    for (int c = 0; c < 2000 && rcv_idx != exp_q.size(); c++)
      @(negedge clk);
    repeat (4) @(negedge clk);  // trailing error pulses
    assert (rcv_idx == exp_q.size()) else begin
      $display("%s: %0d packets never arrived", test_name, exp_q.size() - rcv_idx);
      errs++;
    end
    check_count("frm_err cycles", frm_exp, frm_hi - frm_at);
    check_count("flt_err cycles", flt_exp, flt_hi - flt_at);
    check_count("gch_err cycles", gch_exp, gch_hi - gch_at);
    if (errs + mon_errs == err_at) begin
      tests_ok++;
      $display("%s: ok", test_name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", test_name, errs + mon_errs - err_at);
    end
  endtask

  // blocked output stalls the link and then everything drains in order
  task automatic run_stall();
    int   quiet;
    logic stalled;
    logic ack_prev;
    logic sent_all;  // sender got through every packet
    quiet    = 0;
    stalled  = 1'b0;
    sent_all = 1'b0;
    ack_prev = sl_ack;
    set_rdy(0);
    fork
      begin
        repeat (4) send_good(-1);
        sent_all = 1'b1;
      end
      begin
        for (int c = 0; c < 3000 && !stalled; c++) begin
          @(negedge clk);
          quiet    = (sl_ack == ack_prev) ? quiet + 1 : 0;
          ack_prev = sl_ack;
          stalled  = (quiet >= STALL_CYC);
        end
        assert (stalled && pkt_vld && !sent_all) else begin
          $display("%s: the link did not stall while the output was blocked", test_name);
          errs++;
        end
        set_rdy(1);
      end
    join
  endtask

  // ----------------------------------------------------------------------

  initial begin
    wait (rst == 1'b0);
    assert (!pkt_vld && !sl_ack && !flt_err && !frm_err && !gch_err) else begin
      $display("outputs were not low at the end of reset");
      errs++;
    end
    wait_ack();  // startup toggle opens the link

    start_test("random_rdy_high");
    repeat (8) send_good(-1);
    end_test(0, 0, 0);

    start_test("random_rdy_random");
    set_rdy(2);
    repeat (8) send_good(-1);
    end_test(0, 0, 0);
    set_rdy(1);

    start_test("wrong_flit_count");
    make_pkt();
    send_nibs(n_nibs - 1, -1, -1);  // one data flit short so it is dropped
    send_good(-1);
    end_test(2, 0, 0);

    start_test("bad_symbol");
    make_pkt();
    send_nibs(n_nibs, 3, -1);
    send_good(-1);
    end_test(0, 2, 0);

    start_test("wire_glitch");
    send_good(4);
    end_test(0, 0, 2);

    start_test("output_stall");
    run_stall();
    end_test(0, 0, 0);

    $display("tests %0d ok %0d failed %0d errors %0d",
             tests_ok + tests_bad, tests_ok, tests_bad, errs + mon_errs);
    if (tests_bad == 0 && errs + mon_errs == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  initial begin
    #(WD_NS);
    $display("watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// clock and reset source for the receiver testbench, 100 ns clock and 8 cycles of reset
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_NS = 50;  // half of the 100 ns period

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (8) @(negedge clk);  // released away from the rising edge
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: spl_receiver.sv
// SpiNNaker 2-of-7 link receiver top level, link wires in and assembled packets out
`default_nettype none

module spl_receiver (
  input  wire                         CLK_IN,
  input  wire                         RESET_IN,
  input  wire spl_code_pkg::sym_t     sl_data,   // link wires
  output logic                        sl_ack,    // link ack
  output spl_pkt_pkg::pkt_data_t      pkt_data,
  output logic                        pkt_vld,
  input  wire                         pkt_rdy,
  output logic                        flt_err,   // bad symbol in a packet
  output logic                        frm_err,   // EOP at wrong count
  output logic                        gch_err    // single-cycle glitch
);

  spl_pkt_pkg::flit_t     flit;
  spl_pkt_pkg::pkt_data_t pkt_new_data;

  logic flit_vld;
  logic flit_cts;
  logic pkt_new;
  logic out_free;

  // ------------------------------------------------------------------

  spl_symbol_rx rx_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack),
    .flit     (flit),
    .flit_vld (flit_vld),
    .flit_cts (flit_cts),
    .gch_err  (gch_err)
  );

  spl_pkt_assembler asm_i (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .flit         (flit),
    .flit_vld     (flit_vld),
    .flit_cts     (flit_cts),
    .pkt_new      (pkt_new),
    .pkt_new_data (pkt_new_data),
    .out_free     (out_free),
    .flt_err      (flt_err),
    .frm_err      (frm_err)
  );

  spl_pkt_out out_i (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .pkt_new      (pkt_new),
    .pkt_new_data (pkt_new_data),
    .out_free     (out_free),
    .pkt_data     (pkt_data),
    .pkt_vld      (pkt_vld),
    .pkt_rdy      (pkt_rdy)
  );

endmodule

`default_nettype wire

// File: spl_pkt_out.sv
// packet output side, a one-entry holding register behind a valid/ready port
`default_nettype none

module spl_pkt_out (
  input  wire                        CLK_IN,
  input  wire                        RESET_IN,
  input  wire                        pkt_new,        // load strobe from assembler
  input  wire spl_pkt_pkg::pkt_data_t pkt_new_data,
  output logic                       out_free,       // can load this cycle
  output spl_pkt_pkg::pkt_data_t     pkt_data,
  output logic                       pkt_vld,
  input  wire                        pkt_rdy
);

  // empty, or the held packet leaves on this edge
  assign out_free = !pkt_vld || pkt_rdy;

  // ------------------------------------------------------------------
  // valid flag

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      pkt_vld <= 1'b0;
    else if (pkt_new)
      pkt_vld <= 1'b1;  // new packet replaces the one taken
    else if (pkt_rdy)
      pkt_vld <= 1'b0;  // taken, nothing behind it
  end

  // data only changes on a load, stable under back-pressure
  always_ff @(posedge CLK_IN) begin
    if (pkt_new)
      pkt_data <= pkt_new_data;
  end

endmodule

`default_nettype wire

// File: spl_pkt_assembler.sv
// packet assembly, collects flits into short or long packets and checks their framing
`default_nettype none

module spl_pkt_assembler (
  input  wire                     CLK_IN,
  input  wire                     RESET_IN,
  input  wire spl_pkt_pkg::flit_t flit,
  input  wire                     flit_vld,
  output logic                    flit_cts,
  output logic                    pkt_new,       // one-cycle load strobe
  output spl_pkt_pkg::pkt_data_t  pkt_new_data,
  input  wire                     out_free,
  output logic                    flt_err,
  output logic                    frm_err
);

  spl_pkt_pkg::asm_state_e state;
  spl_pkt_pkg::pkt_data_t  buf_q;      // nibbles enter at the top
  spl_pkt_pkg::flit_cnt_t  cnt_q;      // data and bad flits so far
  spl_pkt_pkg::flit_cnt_t  exp_cnt;    // length the header asks for

  logic       long_q;      // header bit 1, long packet
  logic       bad_seen_q;  // packet already holds a bad flit
  logic       is_dat;
  logic       is_bad;
  logic       is_eop;
  logic       frame_ok;    // EOP arrived at the right count
  logic       pkt_good;
  logic       flt_trig;
  logic       frm_trig;
  logic [1:0] err_d;       // {frm, flt} delayed for the second cycle

  // ------------------------------------------------------------------
  // flit decode and framing check

  // flits are never offered in wait, cts is low there
  assign is_dat = flit_vld && (flit.kind == spl_pkt_pkg::FLIT_DATA);
  assign is_bad = flit_vld && (flit.kind == spl_pkt_pkg::FLIT_BAD);
  assign is_eop = flit_vld && (flit.kind == spl_pkt_pkg::FLIT_EOP);

  assign exp_cnt  = long_q ? spl_pkt_pkg::flit_cnt_t'(spl_pkt_pkg::LPKT_FLTS)
                           : spl_pkt_pkg::flit_cnt_t'(spl_pkt_pkg::SPKT_FLTS);
  assign frame_ok = (state == spl_pkt_pkg::ASM_TRANSFER) && (cnt_q == exp_cnt);
  assign pkt_good = frame_ok && !bad_seen_q;

  assign flt_trig = is_bad && !bad_seen_q;  // only the first one per packet
  assign frm_trig = is_eop && !frame_ok;

  // short packet sits in the upper 40 bits until shifted down
  assign pkt_new_data = long_q ? buf_q : (buf_q >> spl_pkt_pkg::SHORT_SHIFT);

  always_comb begin
    if (state == spl_pkt_pkg::ASM_WAIT)
      pkt_new = out_free;                    // held packet goes out
    else
      pkt_new = is_eop && pkt_good && out_free;
  end

  // ------------------------------------------------------------------
  // data path

  always_ff @(posedge CLK_IN) begin
    if (is_dat)
      buf_q <= {flit.nib, buf_q[spl_pkt_pkg::PKT_BITS-1:4]};
  end

  // ------------------------------------------------------------------
  // FSM and counters

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state      <= spl_pkt_pkg::ASM_IDLE;
      cnt_q      <= '0;
      long_q     <= 1'b0;
      bad_seen_q <= 1'b0;
      flit_cts   <= 1'b0;
    end else begin
      case (state)
        spl_pkt_pkg::ASM_WAIT: begin
          if (out_free) begin
            state    <= spl_pkt_pkg::ASM_IDLE;
            flit_cts <= 1'b1;  // link may move again
          end
        end
        default: begin
          flit_cts <= 1'b1;
          if (is_dat || is_bad) begin
            if (state == spl_pkt_pkg::ASM_IDLE)
              long_q <= flit.nib[1];  // header nibble gives the length
            state <= spl_pkt_pkg::ASM_TRANSFER;
            if (cnt_q != '1)
              cnt_q <= cnt_q + spl_pkt_pkg::flit_cnt_t'(1);  // saturate
            if (is_bad)
              bad_seen_q <= 1'b1;
          end else if (is_eop) begin
            cnt_q      <= '0;
            bad_seen_q <= 1'b0;
            if (pkt_good && !out_free) begin
              state    <= spl_pkt_pkg::ASM_WAIT;  // hold link until output frees
              flit_cts <= 1'b0;
            end else begin
              state <= spl_pkt_pkg::ASM_IDLE;     // sent or dropped
            end
          end
        end
      endcase
    end
  end

  // error pulses, two cycles each
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      err_d   <= 2'b00;
      flt_err <= 1'b0;
      frm_err <= 1'b0;
    end else begin
      err_d   <= {frm_trig, flt_trig};
      flt_err <= flt_trig || err_d[0];
      frm_err <= frm_trig || err_d[1];
    end
  end

endmodule

`default_nettype wire

// File: spl_symbol_rx.sv
// link input side, turns 2-of-7 NRZ wire transitions into flits and drives the toggle ack
`default_nettype none

module spl_symbol_rx (
  input  wire                CLK_IN,
  input  wire                RESET_IN,
  input  wire spl_code_pkg::sym_t sl_data,   // asynchronous link wires
  output logic               sl_ack,         // toggles once per symbol
  output spl_pkt_pkg::flit_t flit,
  output logic               flit_vld,       // one-cycle pulse
  input  wire                flit_cts,       // assembler can take a flit
  output logic               gch_err         // two-cycle glitch report
);

  spl_code_pkg::sym_t       sync_meta;  // first synchronizer stage
  spl_code_pkg::sym_t       sync_q;     // synchronized wires
  spl_code_pkg::sym_t       ref_q;      // wire value after last accepted symbol
  spl_code_pkg::sym_t       sym;        // wires that changed since then
  spl_code_pkg::sym_class_e sym_cls;
  spl_pkt_pkg::rx_state_e   state;
  spl_pkt_pkg::flit_t       cand;       // flit built from current symbol
  spl_pkt_pkg::flit_t       cand_q;     // classification stage

  logic err_seen;   // error pattern present last cycle too
  logic bad_sym;    // error that persisted, not a glitch
  logic accept;     // symbol taken this cycle
  logic acc_q;      // accepted symbol waiting in classification stage
  logic glitch;     // error pattern went away after one cycle
  logic glitch_d;

  // ------------------------------------------------------------------
  // synchronizer and NRZ to RTZ

  always_ff @(posedge CLK_IN) begin
    sync_meta <= sl_data;
    sync_q    <= sync_meta;
  end

  assign sym = sync_q ^ ref_q;  // one bit per wire that toggled

  always_comb begin
    // nothing is classified before the reference is captured
    if (state == spl_pkt_pkg::RX_RUN)
      sym_cls = spl_code_pkg::classify(sym);
    else
      sym_cls = spl_code_pkg::CLS_NONE;
  end

  assign bad_sym = (sym_cls == spl_code_pkg::CLS_ERROR) && err_seen;
  assign glitch  = err_seen && (sym_cls != spl_code_pkg::CLS_ERROR);

  assign accept = flit_cts && ((sym_cls == spl_code_pkg::CLS_DATA) ||
                               (sym_cls == spl_code_pkg::CLS_EOP)  || bad_sym);

  always_comb begin
    cand.nib = spl_code_pkg::decode(sym);
    if (bad_sym)
      cand.kind = spl_pkt_pkg::FLIT_BAD;
    else if (sym_cls == spl_code_pkg::CLS_EOP)
      cand.kind = spl_pkt_pkg::FLIT_EOP;
    else
      cand.kind = spl_pkt_pkg::FLIT_DATA;
  end

  // ------------------------------------------------------------------
  // FSM, reference value and ack

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state  <= spl_pkt_pkg::RX_START;
      ref_q  <= '0;
      sl_ack <= 1'b0;
    end else begin
      case (state)
        spl_pkt_pkg::RX_START: begin
          ref_q  <= sync_q;   // whatever the wires hold now is the base
          sl_ack <= ~sl_ack;  // opens the link like a chip would
          state  <= spl_pkt_pkg::RX_RUN;
        end
        default: begin
          if (accept)
            ref_q <= sync_q;    // next symbol is measured from here
          if (acc_q && flit_cts)
            sl_ack <= ~sl_ack;  // same edge as flit_vld
        end
      endcase
    end
  end

  // glitch filter, an error must be seen twice in a row
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      err_seen <= 1'b0;
      glitch_d <= 1'b0;
      gch_err  <= 1'b0;
    end else begin
      err_seen <= (sym_cls == spl_code_pkg::CLS_ERROR) && !accept;
      glitch_d <= glitch;
      gch_err  <= glitch || glitch_d;  // stretched to two cycles
    end
  end

  // ------------------------------------------------------------------
  // flit pipeline, stalls in place while cts is low

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      acc_q    <= 1'b0;
      flit_vld <= 1'b0;
    end else begin
      if (flit_cts)
        acc_q <= accept;
      flit_vld <= acc_q && flit_cts;
    end
  end

  always_ff @(posedge CLK_IN) begin
    if (flit_cts)
      cand_q <= cand;
    if (acc_q && flit_cts)
      flit <= cand_q;
  end

endmodule

`default_nettype wire

// File: spl_pkt_pkg.sv
// packet and flit definitions shared by the receiver blocks and the testbench
`default_nettype none

package spl_pkt_pkg;

  localparam int PKT_BITS    = 72;  // long packet, header plus payload
  localparam int SPKT_FLTS   = 10;  // nibbles in a short packet
  localparam int LPKT_FLTS   = 18;  // nibbles in a long packet
  localparam int SHORT_SHIFT = 32;  // right-align a short packet

  typedef logic [PKT_BITS-1:0] pkt_data_t;
  typedef logic [4:0]          flit_cnt_t;  // flits seen in current packet

  // what one accepted symbol turned out to be
  typedef enum logic [1:0] {
    FLIT_DATA,
    FLIT_EOP,
    FLIT_BAD
  } flit_kind_e;

  typedef struct packed {
    flit_kind_e           kind;
    spl_code_pkg::nibble_t nib;   // only meaningful for data flits
  } flit_t;

  // symbol receiver FSM
  typedef enum logic {
    RX_START,  // first ack after reset, take initial wire value
    RX_RUN
  } rx_state_e;

  // packet assembler FSM
  typedef enum logic [1:0] {
    ASM_IDLE,      // between packets
    ASM_TRANSFER,  // inside a packet
    ASM_WAIT       // packet done, output still busy
  } asm_state_e;

endpackage

`default_nettype wire

// File: spl_code_pkg.sv
// 2-of-7 link code definitions, shared by the symbol receiver and the testbench encoder
`default_nettype none

package spl_code_pkg;

  typedef logic [6:0] sym_t;     // one value of the seven link wires
  typedef logic [3:0] nibble_t;  // data carried by one symbol

  typedef enum logic [2:0] {
    CLS_NONE,        // nothing looked at yet
    CLS_DATA,        // valid data code
    CLS_EOP,         // end-of-packet code
    CLS_INCOMPLETE,  // no change or a single wire so far
    CLS_ERROR        // two or more wires, not a code
  } sym_class_e;

  localparam int   NUM_CODES = 16;
  localparam sym_t EOP_CODE  = 7'b1100000;  // upper two wires

  // nibble value is the index into this table
  localparam sym_t NIB_CODE [NUM_CODES] = '{
    7'b0010001, 7'b0010010, 7'b0010100, 7'b0011000,  // 0 .. 3
    7'b0100001, 7'b0100010, 7'b0100100, 7'b0101000,  // 4 .. 7
    7'b1000001, 7'b1000010, 7'b1000100, 7'b1001000,  // 8 .. 11
    7'b0000011, 7'b0000110, 7'b0001100, 7'b0001001   // 12 .. 15
  };

  // ------------------------------------------------------------------
  // sort a received symbol into its class
  function automatic sym_class_e classify(input sym_t sym);
    sym_class_e cls;
    if ($countones(sym) < 2)
      cls = CLS_INCOMPLETE;  // still waiting for the second wire
    else
      cls = CLS_ERROR;       // overridden below if it is a real code
    if (sym == EOP_CODE)
      cls = CLS_EOP;
    for (int i = 0; i < NUM_CODES; i++) begin
      if (sym == NIB_CODE[i])
        cls = CLS_DATA;
    end
    return cls;
  endfunction

  // ------------------------------------------------------------------
  // data symbol back to its nibble, zero for anything else
  function automatic nibble_t decode(input sym_t sym);
    nibble_t nib;
    nib = '0;
    for (int i = 0; i < NUM_CODES; i++) begin
      if (sym == NIB_CODE[i])
        nib = nibble_t'(i);
    end
    return nib;
  endfunction

endpackage

`default_nettype wire
